//--- src/id_pkg.sv
// widths, encodings and stage bundles shared by the decode stage, imported by the RTL and bench
`default_nettype none

package id_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;   // data or pc word
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      gpr_addr_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      funct3_t; // branch func and mem op

  // alu operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  localparam alu_op_t ALU_LUI  = 4'd10; // pass src2

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // alu source 2 select
  localparam logic [1:0] SRC2_RS2 = 2'd0;
  localparam logic [1:0] SRC2_IMM = 2'd1;
  localparam logic [1:0] SRC2_PC4 = 2'd2; // link address for jumps

  localparam inst_t NOP_INST = 32'h0000_0013; // addi x0,x0,0
  localparam xlen_t PC_STEP  = 64'd4;

  typedef struct packed {
    gpr_addr_t rd;      // 0 when nothing to forward
    xlen_t     result;
  } bypass_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xlen_t     wdata;
  } wb_to_rf_t;

  typedef struct packed {
    logic  stall;
    logic  taken;
    xlen_t target;
  } br_bus_t;

  typedef struct packed {
    inst_t inst;
    xlen_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      alu_src1_sel; // 1 selects pc
    logic [1:0] alu_src2_sel;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    funct3_t   mem_op;
    logic      load_sel;
    logic      invalid;
  } ds_ctrl_t;

  typedef struct packed {
    ds_ctrl_t ctrl;
    xlen_t    rs1data;
    xlen_t    rs2data;
    xlen_t    imm;
    xlen_t    pc;
  } ds_to_es_t;

endpackage

`default_nettype wire

//--- src/id_decoder.sv
// combinational decoder turning one RV64I instruction into register indices, immediate and controls
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::ds_ctrl_t  o_ctrl,
  output logic              o_br_en,
  output logic              o_jump,   // jal
  output logic              o_jalr,
  output id_pkg::funct3_t   o_br_func
);

  import id_pkg::*;

  logic [6:0] opcode;
  funct3_t    funct3;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_br_func = funct3;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl  = '0;
    o_imm   = '0;
    o_br_en = 1'b0;
    o_jump  = 1'b0;
    o_jalr  = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm               = imm_u;
        o_ctrl.alu_op       = ALU_LUI;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm               = imm_u;
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        o_imm               = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_jump              = (opcode == OPC_JAL);
        o_jalr              = (opcode == OPC_JALR);
        o_ctrl.alu_src1_sel = 1'b1; // rd = pc + 4
        o_ctrl.alu_src2_sel = SRC2_PC4;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm   = imm_b;
        o_br_en = 1'b1;
      end
      OPC_LOAD: begin
        o_imm               = imm_i;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.mem_op       = funct3;
        o_ctrl.load_sel     = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_STORE: begin
        o_imm               = imm_s;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_wen      = 1'b1;
        o_ctrl.mem_op       = funct3;
      end
      OPC_OPIMM: begin
        o_imm               = imm_i;
        o_ctrl.alu_op       = alu_from_funct3(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_OP: begin
        o_ctrl.alu_op  = alu_from_funct3(funct3, i_inst[30]);
        o_ctrl.gpr_wen = 1'b1;
      end
      default: o_ctrl.invalid = 1'b1;
    endcase
    o_ctrl.rd = o_ctrl.gpr_wen ? i_inst[11:7] : '0; // no rd for branch and store
  end

endmodule

`default_nettype wire

//--- src/gpr_file.sv
// 32 x 64 general register file with two combinational reads and one clocked write port
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_raddr1,
  output id_pkg::xlen_t     o_rdata1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xlen_t     o_rdata2,
  input  id_pkg::wb_to_rf_t i_wb
);

  import id_pkg::*;

  xlen_t regs [1:31]; // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_wb.wen && (i_wb.waddr != '0)) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // x0 reads zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- src/operand_bypass.sv
// operand select for one source, preferring execute, then memory, then write-back results
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
  input  id_pkg::gpr_addr_t i_rs,
  input  id_pkg::xlen_t     i_rf_data,
  input  id_pkg::bypass_t   i_es,
  input  id_pkg::bypass_t   i_ms,
  input  id_pkg::bypass_t   i_ws,
  output id_pkg::xlen_t     o_data
);

  import id_pkg::*;

  logic hit_es;
  logic hit_ms;
  logic hit_ws;

  // rd of 0 means the stage has nothing to forward
  assign hit_es = (i_es.rd != '0) && (i_es.rd == i_rs);
  assign hit_ms = (i_ms.rd != '0) && (i_ms.rd == i_rs);
  assign hit_ws = (i_ws.rd != '0) && (i_ws.rd == i_rs);

  always_comb begin
    if (hit_es) begin
      o_data = i_es.result;  // youngest first
    end else if (hit_ms) begin
      o_data = i_ms.result;
    end else if (hit_ws) begin
      o_data = i_ws.result;  // same-cycle write
    end else begin
      o_data = i_rf_data;
    end
  end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
// branch compare and redirect target for the decode stage, reported to fetch on the branch bus
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  logic            i_valid,
  input  logic            i_br_en,
  input  logic            i_jump,
  input  logic            i_jalr,
  input  id_pkg::funct3_t i_br_func,
  input  id_pkg::xlen_t   i_rs1data,
  input  id_pkg::xlen_t   i_rs2data,
  input  id_pkg::xlen_t   i_pc,
  input  id_pkg::xlen_t   i_imm,
  output logic            o_taken,
  output id_pkg::xlen_t   o_target
);

  import id_pkg::*;

  logic  cond;
  xlen_t jalr_sum;

  always_comb begin
    case (i_br_func)
      3'b000:  cond = (i_rs1data == i_rs2data);                 // beq
      3'b001:  cond = (i_rs1data != i_rs2data);                 // bne
      3'b100:  cond = ($signed(i_rs1data) <  $signed(i_rs2data)); // blt
      3'b101:  cond = ($signed(i_rs1data) >= $signed(i_rs2data)); // bge
      3'b110:  cond = (i_rs1data <  i_rs2data);                 // bltu
      3'b111:  cond = (i_rs1data >= i_rs2data);                 // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign o_taken = i_valid && ((i_br_en && cond) || i_jump || i_jalr);

  assign jalr_sum = i_rs1data + i_imm;
  assign o_target = i_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

endmodule

`default_nettype wire

//--- src/id_stage_ctrl.sv
// decode stage valid bit, instruction latch with squash, load-use stall and handshake control
`timescale 1ns/1ps
`default_nettype none

module id_stage_ctrl (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_fs_valid,
  input  id_pkg::fs_to_ds_t i_fs_bus,
  input  logic              i_es_allowin,
  input  logic              i_es_load_sel,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  logic              i_br_taken,
  output logic              o_ds_valid,
  output logic              o_ready_go,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::inst_t     o_ds_inst,
  output id_pkg::xlen_t     o_ds_pc,
  output logic              o_load_stall
);

  import id_pkg::*;

  logic  ds_valid;
  inst_t ds_inst;
  xlen_t ds_pc;

  // load result is not ready until it reaches memory stage
  assign o_load_stall = i_es_load_sel && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  assign o_ready_go       = ~o_load_stall;
  assign o_ds_allowin     = ~ds_valid || (o_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && o_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_inst <= i_br_taken ? NOP_INST : i_fs_bus.inst; // wrong path becomes nop
      ds_pc   <= i_fs_bus.pc;
    end
  end

  assign o_ds_valid = ds_valid;
  assign o_ds_inst  = ds_inst;
  assign o_ds_pc    = ds_pc;

endmodule

`default_nettype wire

//--- src/id_stage.sv
// decode stage top between fetch and execute, wiring control, decoder, register file and branch unit
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic              i_clk,
  input  logic              i_reset,
  // fetch side
  input  logic              i_fs_valid,
  input  id_pkg::fs_to_ds_t i_fs_bus,
  output logic              o_ds_allowin,
  // execute side
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es_bus,
  input  logic              i_es_allowin,
  // redirect to fetch
  output id_pkg::br_bus_t   o_br_bus,
  // forwarding and write-back
  input  id_pkg::bypass_t   i_es_bypass,
  input  id_pkg::bypass_t   i_ms_bypass,
  input  id_pkg::bypass_t   i_ws_bypass,
  input  logic              i_es_load_sel,
  input  id_pkg::wb_to_rf_t i_wb
);

  import id_pkg::*;

  logic      ds_valid;
  logic      ds_load_stall;
  inst_t     ds_inst;
  xlen_t     ds_pc;
  gpr_addr_t rs1, rs2;
  xlen_t     imm;
  ds_ctrl_t  ds_ctrl;
  logic      br_en, jump, jalr;
  funct3_t   br_func;
  xlen_t     rf_rdata1, rf_rdata2;
  xlen_t     rs1data, rs2data;
  logic      br_taken;
  xlen_t     br_target;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_valid       (i_fs_valid),
    .i_fs_bus         (i_fs_bus),
    .i_es_allowin     (i_es_allowin),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_rd          (i_es_bypass.rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_br_taken       (br_taken),
    .o_ds_valid       (ds_valid),
    .o_ready_go       (),         // folded into allowin and valid
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (ds_pc),
    .o_load_stall     (ds_load_stall)
  );

  id_decoder u_decoder (
    .i_inst    (ds_inst),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_imm     (imm),
    .o_ctrl    (ds_ctrl),
    .o_br_en   (br_en),
    .o_jump    (jump),
    .o_jalr    (jalr),
    .o_br_func (br_func)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wb     (i_wb)
  );

  operand_bypass u_bypass_rs1 (
    .i_rs      (rs1),
    .i_rf_data (rf_rdata1),
    .i_es      (i_es_bypass),
    .i_ms      (i_ms_bypass),
    .i_ws      (i_ws_bypass),
    .o_data    (rs1data)
  );

  operand_bypass u_bypass_rs2 (
    .i_rs      (rs2),
    .i_rf_data (rf_rdata2),
    .i_es      (i_es_bypass),
    .i_ms      (i_ms_bypass),
    .i_ws      (i_ws_bypass),
    .o_data    (rs2data)
  );

  branch_unit u_bru (
    .i_valid   (ds_valid),
    .i_br_en   (br_en),
    .i_jump    (jump),
    .i_jalr    (jalr),
    .i_br_func (br_func),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_pc      (ds_pc),
    .i_imm     (imm),
    .o_taken   (br_taken),
    .o_target  (br_target)
  );

  assign o_ds_to_es_bus = '{ctrl: ds_ctrl, rs1data: rs1data, rs2data: rs2data,
                            imm: imm, pc: ds_pc};

  // fetch holds off while the jump operands wait on a load
  assign o_br_bus = '{stall: br_taken && ds_load_stall, taken: br_taken, target: br_target};

endmodule

`default_nettype wire

//--- bench/id_stage_sva.sv
// handshake assertions for the decode stage, attached to every id_stage instance by the bind below
`timescale 1ns/1ps
`default_nettype none

module id_stage_sva (
  input logic i_clk,
  input logic i_reset,
  input logic i_ds_valid,
  input logic i_ds_allowin,
  input logic i_load_stall,
  input logic i_es_valid,
  input logic i_br_taken
);

  int unsigned fail_count = 0;

  // a stalled instruction waits in the stage until its load result can be forwarded
  a_stall_holds: assert property (
    @(posedge i_clk) disable iff (i_reset) i_ds_valid && i_load_stall |=> i_ds_valid
  ) else begin
    $error("stalled instruction left the stage");
    fail_count++;
  end

  // the squashed nop or an empty stage follows a taken redirect
  a_taken_once: assert property (
    @(posedge i_clk) disable iff (i_reset) i_br_taken && i_ds_allowin |=> !i_br_taken
  ) else begin
    $error("branch taken reported twice for one redirect");
    fail_count++;
  end

  a_empty_after_reset: assert property (
    @(posedge i_clk) i_reset |=> !i_es_valid // stage comes out of reset empty
  ) else begin
    $error("execute valid high in the cycle after reset");
    fail_count++;
  end

endmodule

bind id_stage id_stage_sva u_sva (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_ds_valid   (ds_valid),
  .i_ds_allowin (o_ds_allowin),
  .i_load_stall (ds_load_stall),
  .i_es_valid   (o_ds_to_es_valid),
  .i_br_taken   (o_br_bus.taken)
);

`default_nettype wire

//--- bench/id_stage_tb.sv
// directed testbench for id_stage, run as the top module after compiling the file list
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;

  import id_pkg::*;

  localparam int    CLK_PERIOD = 4;
  localparam int    NUM_TESTS  = 6;
  localparam inst_t NEXT_INST  = {12'h055, 5'd1, 3'b110, 5'd9, OPC_OPIMM}; // ori x9,x1,0x55

  logic      clk = 1'b0;
  logic      reset, fs_valid, ds_allowin, ds_to_es_valid, es_allowin, es_load_sel;
  fs_to_ds_t fs_bus;
  ds_to_es_t ds_to_es_bus;
  br_bus_t   br_bus;
  bypass_t   es_bypass, ms_bypass, ws_bypass;
  wb_to_rf_t wb;
  xlen_t     model [0:31]; // expected register contents
  int        test_errs = 0;
  int        total_errs = 0;
  int        tests_run = 0;
  int        tests_bad = 0;

  id_stage uut (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_fs_valid       (fs_valid),
    .i_fs_bus         (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .i_es_allowin     (es_allowin),
    .o_br_bus         (br_bus),
    .i_es_bypass      (es_bypass),
    .i_ms_bypass      (ms_bypass),
    .i_ws_bypass      (ws_bypass),
    .i_es_load_sel    (es_load_sel),
    .i_wb             (wb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // instruction encoders, field order from the RISC-V formats
  function automatic inst_t enc_i(input logic [11:0] imm, input gpr_addr_t rs1,
                                  input funct3_t f3, input gpr_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input gpr_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_errs);
      tests_bad++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // hand one instruction to the stage, return at the negedge after it is latched
  task automatic send(input inst_t inst, input xlen_t pc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_bus   <= '{inst: inst, pc: pc};
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
  endtask

  // empty the stage; hold keeps execute closed for the next instruction
  task automatic drain(input logic hold);
    @(posedge clk);
    fs_valid    <= 1'b0;
    es_allowin  <= 1'b1;
    es_load_sel <= 1'b0;
    es_bypass   <= '0;
    ms_bypass   <= '0;
    ws_bypass   <= '0;
    @(posedge clk);
    es_allowin  <= !hold;
  endtask

  task automatic fill_regs;
    model[0] = '0;
    for (int i = 1; i < 32; i++) begin
      model[i] = {$urandom, $urandom};
    end
    model[15] = ~model[14]; // unequal branch operands
    for (int i = 1; i < 32; i++) begin
      @(posedge clk);
      wb <= '{wen: 1'b1, waddr: gpr_addr_t'(i), wdata: model[i]};
    end
    @(posedge clk);
    wb <= '0;
  endtask

  task automatic check_opimm(input funct3_t f3, input int imm_val, input gpr_addr_t rs1,
                             input gpr_addr_t rd, input alu_op_t exp_op, input xlen_t pc);
    xlen_t exp_imm;
    exp_imm = imm_val; // sign extends
    send(enc_i(imm_val[11:0], rs1, f3, rd, OPC_OPIMM), pc);
    compare("valid", ds_to_es_valid, 1'b1);
    compare("rs1data", ds_to_es_bus.rs1data, model[rs1]);
    compare("imm", ds_to_es_bus.imm, exp_imm);
    compare("alu_op", ds_to_es_bus.ctrl.alu_op, exp_op);
    compare("gpr_wen", ds_to_es_bus.ctrl.gpr_wen, 1'b1);
    compare("rd", ds_to_es_bus.ctrl.rd, rd);
  endtask

  // fetch offers NEXT_INST while the branch sits in decode
  task automatic check_branch(input inst_t inst, input xlen_t pc, input logic exp_taken,
                              input xlen_t exp_target);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_bus   <= '{inst: inst, pc: pc};
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(posedge clk);
    fs_bus <= '{inst: NEXT_INST, pc: pc + PC_STEP};
    @(negedge clk);
    compare("br taken", br_bus.taken, exp_taken);
    if (exp_taken) begin
      compare("br target", br_bus.target, exp_target);
    end
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
    compare("next pc", ds_to_es_bus.pc, pc + PC_STEP);
    compare("next inst", uut.ds_inst, exp_taken ? NOP_INST : NEXT_INST);
    compare("next rd", ds_to_es_bus.ctrl.rd, exp_taken ? 5'd0 : 5'd9);
  endtask

  task automatic test_imm_alu;
    check_opimm(3'b000, -5, 5'd3, 5'd5, ALU_ADD, 64'h1000);    // addi
    check_opimm(3'b010, 100, 5'd7, 5'd6, ALU_SLT, 64'h1004);   // slti
    check_opimm(3'b111, -2048, 5'd9, 5'd8, ALU_AND, 64'h1008); // andi
    finish_test("imm_alu_decode");
  endtask

  task automatic test_bypass_priority;
    drain(1'b1);
    send(enc_i({7'd0, 5'd0}, 5'd4, 3'b000, 5'd10, OPC_OP), 64'h2000); // add x10,x4,x0
    @(posedge clk);
    ws_bypass <= '{rd: 5'd4, result: 64'h1111};
    ms_bypass <= '{rd: 5'd4, result: 64'h2222};
    es_bypass <= '{rd: 5'd4, result: 64'h3333};
    @(negedge clk);
    compare("rs1data from execute", ds_to_es_bus.rs1data, 64'h3333);
    compare("rs2data of x0", ds_to_es_bus.rs2data, 64'h0);
    @(posedge clk);
    es_bypass <= '{rd: 5'd0, result: 64'h3333};
    @(negedge clk);
    compare("rs1data from memory", ds_to_es_bus.rs1data, 64'h2222);
    @(posedge clk);
    ws_bypass <= '{rd: 5'd0, result: 64'h1111};
    ms_bypass <= '{rd: 5'd0, result: 64'h2222};
    es_bypass <= '{rd: 5'd0, result: 64'h3333};
    @(negedge clk);
    compare("rs1data from regfile", ds_to_es_bus.rs1data, model[4]);
    compare("rs2data of x0", ds_to_es_bus.rs2data, 64'h0);
    finish_test("bypass_priority");
  endtask

  task automatic test_load_use_stall;
    drain(1'b0);
    es_load_sel <= 1'b1;
    es_bypass   <= '{rd: 5'd13, result: 64'h4444};
    send(enc_i({7'd0, 5'd13}, 5'd12, 3'b000, 5'd11, OPC_OP), 64'h3000); // add x11,x12,x13
    repeat (3) begin
      compare("valid in stall", ds_to_es_valid, 1'b0);
      compare("allowin in stall", ds_allowin, 1'b0);
      @(negedge clk);
    end
    @(posedge clk);
    es_load_sel <= 1'b0;
    es_bypass   <= '0;
    @(negedge clk);
    compare("valid after stall", ds_to_es_valid, 1'b1);
    compare("pc after stall", ds_to_es_bus.pc, 64'h3000);
    compare("rd after stall", ds_to_es_bus.ctrl.rd, 5'd11);
    compare("rs2data after stall", ds_to_es_bus.rs2data, model[13]);
    // jump base waiting on a load holds fetch off
    @(posedge clk);
    es_load_sel <= 1'b1;
    es_bypass   <= '{rd: 5'd14, result: 64'h5555};
    send(enc_i(12'h021, 5'd14, 3'b000, 5'd1, OPC_JALR), 64'h3100); // jalr x1,33(x14)
    compare("jump taken in stall", br_bus.taken, 1'b1);
    compare("jump stall", br_bus.stall, 1'b1);
    @(posedge clk);
    es_load_sel <= 1'b0;
    es_bypass   <= '0;
    @(negedge clk);
    compare("jump stall released", br_bus.stall, 1'b0);
    finish_test("load_use_stall");
  endtask

  task automatic test_back_pressure;
    ds_ctrl_t exp_ctrl;
    exp_ctrl              = '0;
    exp_ctrl.alu_op       = ALU_XOR;
    exp_ctrl.alu_src2_sel = SRC2_IMM;
    exp_ctrl.rd           = 5'd21;
    exp_ctrl.gpr_wen      = 1'b1;
    drain(1'b1);
    send(enc_i(12'h123, 5'd20, 3'b100, 5'd21, OPC_OPIMM), 64'h4000); // xori
    repeat (4) begin
      compare("allowin held", ds_allowin, 1'b0);
      compare("valid held", ds_to_es_valid, 1'b1);
      compare("pc held", ds_to_es_bus.pc, 64'h4000);
      compare("ctrl held", ds_to_es_bus.ctrl, exp_ctrl);
      @(negedge clk);
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    send(enc_i(12'h00f, 5'd22, 3'b110, 5'd23, OPC_OPIMM), 64'h4004); // ori
    compare("next pc", ds_to_es_bus.pc, 64'h4004);
    compare("next rd", ds_to_es_bus.ctrl.rd, 5'd23);
    finish_test("back_pressure");
  endtask

  task automatic test_branch_squash;
    drain(1'b0);
    check_branch(enc_b(13'h1ff0, 5'd14, 5'd14, 3'b000), 64'h5000, 1'b1, 64'h4ff0); // beq -16
    check_branch(enc_b(13'h1ff0, 5'd15, 5'd14, 3'b000), 64'h5100, 1'b0, 64'h0);
    check_branch(enc_j(21'h100, 5'd1), 64'h5200, 1'b1, 64'h5300);
    check_branch(enc_i(12'h021, 5'd14, 3'b000, 5'd1, OPC_JALR), 64'h5400, 1'b1,
                 (model[14] + 64'd33) & ~64'd1);
    finish_test("branch_squash");
  endtask

  task automatic test_mem_invalid;
    send(enc_i(12'd24, 5'd17, 3'b011, 5'd16, OPC_LOAD), 64'h6000); // ld x16,24(x17)
    compare("ld mem_ren", ds_to_es_bus.ctrl.mem_ren, 1'b1);
    compare("ld load_sel", ds_to_es_bus.ctrl.load_sel, 1'b1);
    compare("ld mem_op", ds_to_es_bus.ctrl.mem_op, 3'b011);
    compare("ld imm", ds_to_es_bus.imm, 64'd24);
    send(enc_s(12'hfd8, 5'd18, 5'd19, 3'b011), 64'h6004); // sd x18,-40(x19)
    compare("sd mem_wen", ds_to_es_bus.ctrl.mem_wen, 1'b1);
    compare("sd gpr_wen", ds_to_es_bus.ctrl.gpr_wen, 1'b0);
    compare("sd imm", ds_to_es_bus.imm, 64'hffff_ffff_ffff_ffd8);
    send(32'h0000_007f, 64'h6008);
    compare("invalid", ds_to_es_bus.ctrl.invalid, 1'b1);
    compare("invalid gpr_wen", ds_to_es_bus.ctrl.gpr_wen, 1'b0);
    compare("invalid mem_ren", ds_to_es_bus.ctrl.mem_ren, 1'b0);
    compare("invalid mem_wen", ds_to_es_bus.ctrl.mem_wen, 1'b0);
    finish_test("mem_invalid");
  endtask

  initial begin
    #(200 * NUM_TESTS * CLK_PERIOD);
    $display("timeout: tests did not finish within the watchdog limit");
    $display("Regression failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    fs_valid    = 1'b0;
    fs_bus      = '0;
    es_allowin  = 1'b1;
    es_load_sel = 1'b0;
    es_bypass   = '0;
    ms_bypass   = '0;
    ws_bypass   = '0;
    wb          = '0;
    void'($urandom(38089));
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    fill_regs();
    test_imm_alu();
    test_bypass_priority();
    test_load_use_stall();
    test_back_pressure();
    test_branch_squash();
    test_mem_invalid();
    $display("tests run %0d, tests with errors %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_bad, total_errs, uut.u_sva.fail_count);
    if (total_errs == 0 && uut.u_sva.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_id_stage.f
src/id_pkg.sv
src/id_decoder.sv
src/gpr_file.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage_ctrl.sv
src/id_stage.sv
bench/id_stage_sva.sv
bench/id_stage_tb.sv
